/* Makefile */
# Verilator build and run of the snoop interconnect testbench.

VERILATOR ?= verilator
TOP       ?= tb_snoop_interconnect
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing
WFLAGS    ?= -Wno-fatal
FILELIST  ?= list.f

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) $(WFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/snoop_interconnect.sv */
`timescale 1ns/1ps

module snoop_interconnect #(
    parameter int unsigned NumInp   = 3,
    parameter int unsigned NumOup   = 4,
    parameter int unsigned ReqDepth = 4,
    parameter int unsigned SelDepth = 4
) (
    input  logic                                     clk_i,
    input  logic                                     rst_i,

    input  logic                [NumInp-1:0]             inp_ac_valid_i,
    output logic                [NumInp-1:0]             inp_ac_ready_o,
    input  snoop_pkg::ac_chan_t [NumInp-1:0]             inp_ac_i,
    input  logic                [NumInp-1:0][NumOup-1:0] inp_sel_i,
    output logic                [NumInp-1:0]             inp_cr_valid_o,
    input  logic                [NumInp-1:0]             inp_cr_ready_i,
    output snoop_pkg::cr_resp_t [NumInp-1:0]             inp_cr_o,

    output logic                [NumOup-1:0]             oup_ac_valid_o,
    input  logic                [NumOup-1:0]             oup_ac_ready_i,
    output snoop_pkg::ac_chan_t [NumOup-1:0]             oup_ac_o,
    input  logic                [NumOup-1:0]             oup_cr_valid_i,
    output logic                [NumOup-1:0]             oup_cr_ready_o,
    input  snoop_pkg::cr_resp_t [NumOup-1:0]             oup_cr_i
);

    localparam int unsigned IdxWidth = (NumInp > 1) ? $clog2(NumInp) : 1;

    logic                [NumOup-1:0]             port_ac_valid;
    logic                [NumOup-1:0]             port_ac_ready;
    snoop_pkg::ac_chan_t                          port_ac;
    logic                [IdxWidth-1:0]           port_idx;

    logic                [NumInp-1:0]             sel_push;
    logic                [NumOup-1:0]             sel_mask;
    logic                [NumInp-1:0]             sel_ready;

    logic                [NumOup-1:0][NumInp-1:0] resp_valid;  // indexed [port][initiator].
    logic                [NumOup-1:0][NumInp-1:0] resp_ready;
    logic                [NumInp-1:0][NumOup-1:0] resp_valid_t; // indexed [initiator][port].
    logic                [NumInp-1:0][NumOup-1:0] resp_ready_t;
    snoop_pkg::cr_resp_t [NumOup-1:0]             resp_cr;

    // ==============================
    // request path
    // ==============================

    snoop_req_router #(
        .NumInp (NumInp),
        .NumOup (NumOup)
    ) i_req_router (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .inp_ac_valid_i  (inp_ac_valid_i),
        .inp_ac_ready_o  (inp_ac_ready_o),
        .inp_ac_i        (inp_ac_i),
        .inp_sel_i       (inp_sel_i),
        .sel_ready_i     (sel_ready),
        .sel_push_o      (sel_push),
        .sel_mask_o      (sel_mask),
        .port_ac_valid_o (port_ac_valid),
        .port_ac_ready_i (port_ac_ready),
        .port_ac_o       (port_ac),
        .port_idx_o      (port_idx)
    );

    for (genvar j = 0; j < NumOup; j++) begin : gen_port
        snoop_port #(
            .NumInp   (NumInp),
            .ReqDepth (ReqDepth)
        ) i_snoop_port (
            .clk_i           (clk_i),
            .rst_i           (rst_i),
            .port_ac_valid_i (port_ac_valid[j]),
            .port_ac_ready_o (port_ac_ready[j]),
            .port_ac_i       (port_ac),
            .port_idx_i      (port_idx),
            .oup_ac_valid_o  (oup_ac_valid_o[j]),
            .oup_ac_ready_i  (oup_ac_ready_i[j]),
            .oup_ac_o        (oup_ac_o[j]),
            .oup_cr_valid_i  (oup_cr_valid_i[j]),
            .oup_cr_ready_o  (oup_cr_ready_o[j]),
            .oup_cr_i        (oup_cr_i[j]),
            .resp_valid_o    (resp_valid[j]),
            .resp_ready_i    (resp_ready[j]),
            .resp_cr_o       (resp_cr[j])
        );
    end

    // ==============================
    // response path
    // ==============================

    for (genvar i = 0; i < NumInp; i++) begin : gen_xpose_inp
        for (genvar j = 0; j < NumOup; j++) begin : gen_xpose_oup
            assign resp_valid_t[i][j] = resp_valid[j][i];
            assign resp_ready[j][i]   = resp_ready_t[i][j];
        end
    end

    for (genvar i = 0; i < NumInp; i++) begin : gen_merge
        snoop_resp_merge #(
            .NumOup   (NumOup),
            .SelDepth (SelDepth)
        ) i_resp_merge (
            .clk_i          (clk_i),
            .rst_i          (rst_i),
            .sel_push_i     (sel_push[i]),
            .sel_mask_i     (sel_mask),
            .sel_ready_o    (sel_ready[i]),
            .resp_valid_i   (resp_valid_t[i]),
            .resp_ready_o   (resp_ready_t[i]),
            .resp_cr_i      (resp_cr),
            .inp_cr_valid_o (inp_cr_valid_o[i]),
            .inp_cr_ready_i (inp_cr_ready_i[i]),
            .inp_cr_o       (inp_cr_o[i])
        );
    end

endmodule

/* design/snoop_pkg.sv */
package snoop_pkg;

    // ==============================
    // AC channel
    // ==============================

    localparam int unsigned AcAddrWidth  = 32;
    localparam int unsigned AcSnoopWidth = 4;
    localparam int unsigned AcWidth      = AcAddrWidth + AcSnoopWidth;

    // the address sits in the upper bits and the snoop opcode in the lower ones.
    typedef logic [AcWidth-1:0] ac_chan_t;

    // ==============================
    // CR channel
    // ==============================

    // Bit 0 DataTransfer, bit 1 Error, bit 2 PassDirty, bit 3 IsShared, bit 4 WasUnique.
    localparam int unsigned CrWidth = 5;

    typedef logic [CrWidth-1:0] cr_resp_t; // flags from several targets merge by OR.

endpackage

/* design/snoop_port.sv */
`timescale 1ns/1ps

module snoop_port #(
    parameter int unsigned NumInp   = 3,
    parameter int unsigned ReqDepth = 4
) (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  logic                                       port_ac_valid_i,
    output logic                                       port_ac_ready_o,
    input  snoop_pkg::ac_chan_t                        port_ac_i,
    input  logic [((NumInp > 1) ? $clog2(NumInp) : 1)-1:0] port_idx_i,
    output logic                                       oup_ac_valid_o,
    input  logic                                       oup_ac_ready_i,
    output snoop_pkg::ac_chan_t                        oup_ac_o,
    input  logic                                       oup_cr_valid_i,
    output logic                                       oup_cr_ready_o,
    input  snoop_pkg::cr_resp_t                        oup_cr_i,
    output logic [NumInp-1:0]                          resp_valid_o,
    input  logic [NumInp-1:0]                          resp_ready_i,
    output snoop_pkg::cr_resp_t                        resp_cr_o
);

    localparam int unsigned IdxWidth = (NumInp > 1) ? $clog2(NumInp) : 1;

    typedef logic [IdxWidth-1:0] idx_t;

    logic q_ready;
    logic q_push;
    logic q_valid;
    logic q_pop;
    idx_t q_idx;

    // ==============================
    // request side
    // ==============================

    // without room for the index the request is not offered outside.
    assign oup_ac_valid_o  = port_ac_valid_i && q_ready;
    assign oup_ac_o        = port_ac_i;
    assign port_ac_ready_o = oup_ac_ready_i && q_ready;
    assign q_push          = oup_ac_valid_o && oup_ac_ready_i;

    stream_fifo #(
        .type_t (idx_t),
        .Depth  (ReqDepth)
    ) i_idx_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (q_push),
        .ready_o (q_ready),
        .data_i  (port_idx_i),
        .valid_o (q_valid),
        .ready_i (q_pop),
        .data_o  (q_idx)
    );

    // ==============================
    // response side
    // ==============================

    always_comb begin
        for (int unsigned i = 0; i < NumInp; i++) begin
            resp_valid_o[i] = oup_cr_valid_i && q_valid && (q_idx == IdxWidth'(i));
        end
    end

    assign resp_cr_o      = oup_cr_i; // passes straight through to the owner.
    assign oup_cr_ready_o = q_valid && resp_ready_i[q_idx];
    assign q_pop          = oup_cr_valid_i && oup_cr_ready_o;

    // the target answers only snoops that it was actually sent.
    a_cr_has_owner: assert property (@(posedge clk_i) disable iff (rst_i)
        oup_cr_valid_i |-> q_valid)
        else $error("snoop_port: CR offered with no snoop outstanding");

endmodule

/* design/snoop_req_router.sv */
`timescale 1ns/1ps

module snoop_req_router #(
    parameter int unsigned NumInp = 3,
    parameter int unsigned NumOup = 4
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                [NumInp-1:0]             inp_ac_valid_i,
    output logic                [NumInp-1:0]             inp_ac_ready_o,
    input  snoop_pkg::ac_chan_t [NumInp-1:0]             inp_ac_i,
    input  logic                [NumInp-1:0][NumOup-1:0] inp_sel_i,
    input  logic                [NumInp-1:0]             sel_ready_i,
    output logic                [NumInp-1:0]             sel_push_o,
    output logic                [NumOup-1:0]             sel_mask_o,
    output logic                [NumOup-1:0]             port_ac_valid_o,
    input  logic                [NumOup-1:0]             port_ac_ready_i,
    output snoop_pkg::ac_chan_t                          port_ac_o,
    output logic [((NumInp > 1) ? $clog2(NumInp) : 1)-1:0] port_idx_o
);

    localparam int unsigned IdxWidth = (NumInp > 1) ? $clog2(NumInp) : 1;

    logic [NumInp-1:0]   eligible;
    logic                win_found;
    logic [IdxWidth-1:0] win_idx;
    logic [IdxWidth-1:0] rr_q;
    logic [NumOup-1:0]   pend_q;
    logic [NumOup-1:0]   pend_left;
    logic                free;
    logic                accept;
    snoop_pkg::ac_chan_t ac_q;
    logic [IdxWidth-1:0] idx_q;

    // ==============================
    // arbitration
    // ==============================

    // an initiator competes only if its merger can take the mask.
    assign eligible = inp_ac_valid_i & sel_ready_i;

    always_comb begin
        int unsigned cand;
        win_found = 1'b0;
        win_idx   = '0;
        cand      = 0;
        for (int unsigned k = 1; k <= NumInp; k++) begin
            cand = (int'(rr_q) + k) % NumInp; // search starts after the last winner.
            if (!win_found && eligible[cand]) begin
                win_found = 1'b1;
                win_idx   = IdxWidth'(cand);
            end
        end
    end

    // bits still owed after this cycle's port transfers.
    assign pend_left = pend_q & ~port_ac_ready_i;
    assign free      = (pend_left == '0);
    assign accept    = free && win_found;

    always_comb begin
        for (int unsigned i = 0; i < NumInp; i++) begin
            inp_ac_ready_o[i] = accept && (win_idx == IdxWidth'(i));
        end
    end

    assign sel_push_o = inp_ac_ready_o; // the mask enters the merger with the request.
    assign sel_mask_o = inp_sel_i[win_idx];

    // ==============================
    // request register
    // ==============================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= '0;
            rr_q   <= IdxWidth'(NumInp - 1);
        end else if (accept) begin
            pend_q <= inp_sel_i[win_idx];
            rr_q   <= win_idx;
        end else begin
            pend_q <= pend_left;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ac_q  <= inp_ac_i[win_idx];
            idx_q <= win_idx;
        end
    end

    assign port_ac_valid_o = pend_q;
    assign port_ac_o       = ac_q;
    assign port_idx_o      = idx_q;

    // an initiator keeps its request steady until the router takes it.
    for (genvar i = 0; i < NumInp; i++) begin : gen_inp_chk
        a_inp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
            inp_ac_valid_i[i] && !inp_ac_ready_o[i] |=>
                inp_ac_valid_i[i] && $stable(inp_ac_i[i]) && $stable(inp_sel_i[i]))
            else $error("snoop_req_router: request withdrawn or changed before it was taken");
    end

endmodule

/* design/snoop_resp_merge.sv */
`timescale 1ns/1ps

module snoop_resp_merge #(
    parameter int unsigned NumOup   = 4,
    parameter int unsigned SelDepth = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                sel_push_i,
    input  logic                [NumOup-1:0]    sel_mask_i,
    output logic                                sel_ready_o,
    input  logic                [NumOup-1:0]    resp_valid_i,
    output logic                [NumOup-1:0]    resp_ready_o,
    input  snoop_pkg::cr_resp_t [NumOup-1:0]    resp_cr_i,
    output logic                                inp_cr_valid_o,
    input  logic                                inp_cr_ready_i,
    output snoop_pkg::cr_resp_t                 inp_cr_o
);

    typedef logic [NumOup-1:0] mask_t;

    logic  mask_valid;
    mask_t head_mask;
    logic  all_in;
    logic  mask_pop;
    logic  done;

    // masks are queued in issue order, one per outstanding snoop.
    stream_fifo #(
        .type_t (mask_t),
        .Depth  (SelDepth)
    ) i_sel_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (sel_push_i),
        .ready_o (sel_ready_o),
        .data_i  (sel_mask_i),
        .valid_o (mask_valid),
        .ready_i (mask_pop),
        .data_o  (head_mask)
    );

    // ==============================
    // merge
    // ==============================

    // a zero mask counts as complete right away.
    assign all_in = ((resp_valid_i & head_mask) == head_mask);

    assign inp_cr_valid_o = mask_valid && all_in;
    assign done           = inp_cr_valid_o && inp_cr_ready_i;
    assign mask_pop       = done;

    always_comb begin
        inp_cr_o = '0;
        for (int unsigned j = 0; j < NumOup; j++) begin
            if (head_mask[j]) begin
                inp_cr_o = inp_cr_o | resp_cr_i[j];
            end
        end
    end

    // all selected ports are released in the same cycle.
    assign resp_ready_o = done ? head_mask : '0;

endmodule

/* design/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
    parameter type         type_t = logic,
    parameter int unsigned Depth  = 4
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  valid_i,
    output logic  ready_o,
    input  type_t data_i,
    output logic  valid_o,
    input  logic  ready_i,
    output type_t data_o
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    type_t               mem_q [Depth];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                push;
    logic                pop;

    function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(Depth - 1)) begin
            return '0; // wrap around the circular buffer.
        end
        return ptr + 1'b1;
    endfunction

    assign ready_o = (count_q != CntWidth'(Depth));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign push = valid_i && ready_o;
    assign pop  = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither keeps the level.
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // the users push only when there is room and pop only when there is data.
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> ready_o)
        else $error("stream_fifo: push into a full queue");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
        ready_i |-> valid_o)
        else $error("stream_fifo: pop from an empty queue");

endmodule

/* list.f */
design/snoop_pkg.sv
design/stream_fifo.sv
design/snoop_req_router.sv
design/snoop_port.sv
design/snoop_resp_merge.sv
design/snoop_interconnect.sv
tb/snoop_checker.sv
tb/tb_snoop_interconnect.sv

/* tb/snoop_checker.sv */
`timescale 1ns/1ps

module snoop_checker #(
    parameter int unsigned NumInp = 3,
    parameter int unsigned NumOup = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                [NumInp-1:0]             in_ac_valid_i,
    input  logic                [NumInp-1:0]             in_ac_ready_i,
    input  snoop_pkg::ac_chan_t [NumInp-1:0]             in_ac_i,
    input  logic                [NumInp-1:0][NumOup-1:0] in_sel_i,
    input  logic                [NumInp-1:0]             in_cr_valid_i,
    input  logic                [NumInp-1:0]             in_cr_ready_i,
    input  snoop_pkg::cr_resp_t [NumInp-1:0]             in_cr_i,
    input  logic                [NumOup-1:0]             out_ac_valid_i,
    input  logic                [NumOup-1:0]             out_ac_ready_i,
    input  snoop_pkg::ac_chan_t [NumOup-1:0]             out_ac_i,
    input  logic                [NumOup-1:0]             out_cr_ready_i,
    input  int                                      test_num_i,
    input  logic                                    test_end_i,
    input  logic                                    run_end_i,
    output int                                      errors_o
);

    snoop_pkg::ac_chan_t tgt_q  [NumOup][$]; // snoops each target has yet to see, in order.
    snoop_pkg::ac_chan_t req_q  [NumInp][$];
    logic [NumOup-1:0]   mask_q [NumInp][$];
    int                  checks    = 0;
    int                  errors    = 0;
    int                  test_chks = 0;
    int                  test_errs = 0;

    assign errors_o = errors;

    // every selected target answers with the low address bits XOR its index.
    function automatic snoop_pkg::cr_resp_t expected_cr(input snoop_pkg::ac_chan_t ac,
                                                        input logic [NumOup-1:0] mask);
        snoop_pkg::cr_resp_t acc;
        logic [snoop_pkg::AcAddrWidth-1:0] addr;
        acc  = '0;
        addr = ac[snoop_pkg::AcWidth-1:snoop_pkg::AcSnoopWidth];
        for (int j = 0; j < NumOup; j++) begin
            if (mask[j]) acc = acc | (snoop_pkg::cr_resp_t'(addr) ^ snoop_pkg::cr_resp_t'(j));
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        test_chks++;
        if (exp !== act) begin
            $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns: %s", $time, what);
        errors++;
        test_errs++;
    endtask

    always @(posedge clk_i) begin
        snoop_pkg::ac_chan_t ac;
        logic [NumOup-1:0]   mask;
        logic [NumOup-1:0]   released;
        int                  accepts;
        if (!rst_i) begin
            // ==============================
            // target side
            for (int j = 0; j < NumOup; j++) begin
                if (out_ac_valid_i[j] && tgt_q[j].size() == 0) begin
                    report_failure($sformatf("target %0d is offered a snoop nobody sent it", j));
                end else if (out_ac_valid_i[j] && out_ac_ready_i[j]) begin
                    ac = tgt_q[j].pop_front();
                    check_value($sformatf("oup_ac_o[%0d]", j), 64'(ac), 64'(out_ac_i[j]));
                end
            end
            // ==============================
            // initiator side
            accepts  = 0;
            released = '0;
            for (int i = 0; i < NumInp; i++) begin
                if (in_cr_valid_i[i] && req_q[i].size() == 0) begin
                    report_failure($sformatf("initiator %0d gets a response it never asked for", i));
                end else if (in_cr_valid_i[i] && in_cr_ready_i[i]) begin
                    ac       = req_q[i].pop_front();
                    mask     = mask_q[i].pop_front();
                    released = released | mask; // its targets are freed in the same cycle.
                    check_value($sformatf("inp_cr_o[%0d]", i), 64'(expected_cr(ac, mask)),
                                64'(in_cr_i[i]));
                end
                if (in_ac_ready_i[i] && !in_ac_valid_i[i]) begin
                    report_failure($sformatf("inp_ac_ready_o[%0d] is high with no request", i));
                end
                if (in_ac_valid_i[i] && in_ac_ready_i[i]) begin
                    accepts++;
                    req_q[i].push_back(in_ac_i[i]);
                    mask_q[i].push_back(in_sel_i[i]);
                    for (int j = 0; j < NumOup; j++) begin
                        if (in_sel_i[i][j]) tgt_q[j].push_back(in_ac_i[i]);
                    end
                end
            end
            if (accepts > 1) report_failure("the router took two requests in one cycle");
            if (released != '0 || out_cr_ready_i != '0) begin
                check_value("oup_cr_ready_o", 64'(released), 64'(out_cr_ready_i));
            end

            if (test_end_i) begin
                for (int j = 0; j < NumOup; j++) begin
                    if (tgt_q[j].size() != 0) begin
                        report_failure($sformatf("target %0d never received %0d snoops",
                                                 j, tgt_q[j].size()));
                    end
                end
                for (int i = 0; i < NumInp; i++) begin
                    if (req_q[i].size() != 0) begin
                        report_failure($sformatf("initiator %0d still waits for %0d responses",
                                                 i, req_q[i].size()));
                    end
                end
                $display("test %0d finished: %0d checks, %0d errors",
                         test_num_i, test_chks, test_errs);
                test_chks = 0;
                test_errs = 0;
            end
            if (run_end_i) $display("all tests: %0d checks, %0d errors", checks, errors);
        end
    end

endmodule

/* tb/tb_snoop_interconnect.sv */
`timescale 1ns/1ps

module tb_snoop_interconnect;

    localparam int unsigned NumInp     = 3;
    localparam int unsigned NumOup     = 4;
    localparam int unsigned ReqDepth   = 4;
    localparam int unsigned SelDepth   = 4;
    localparam int unsigned RandPerInp = 20;
    localparam int unsigned NumReqs    = 3 + NumInp * RandPerInp;
    localparam int unsigned Watchdog   = NumReqs * 200 + 100; // in clock cycles.

    logic                                    clk_i;
    logic                                    rst_i;
    logic                [NumInp-1:0]             inp_ac_valid;
    logic                [NumInp-1:0]             inp_ac_ready;
    snoop_pkg::ac_chan_t [NumInp-1:0]             inp_ac;
    logic                [NumInp-1:0][NumOup-1:0] inp_sel;
    logic                [NumInp-1:0]             inp_cr_valid;
    logic                [NumInp-1:0]             inp_cr_ready;
    snoop_pkg::cr_resp_t [NumInp-1:0]             inp_cr;
    logic                [NumOup-1:0]             oup_ac_valid;
    logic                [NumOup-1:0]             oup_ac_ready;
    snoop_pkg::ac_chan_t [NumOup-1:0]             oup_ac;
    logic                [NumOup-1:0]             oup_cr_valid;
    logic                [NumOup-1:0]             oup_cr_ready;
    snoop_pkg::cr_resp_t [NumOup-1:0]             oup_cr;

    int   test_num;
    logic test_end;
    logic run_end;
    int   errors;

    snoop_pkg::ac_chan_t req_ac   [NumInp][$]; // requests each initiator still has to send.
    logic [NumOup-1:0]   req_sel  [NumInp][$];
    snoop_pkg::ac_chan_t tgt_pend [NumOup][$]; // snoops each target still has to answer.
    logic [NumInp-1:0]   ac_taken;
    logic [NumOup-1:0]   cr_taken;
    int                  issued  [NumInp];
    int                  cr_seen [NumInp];
    int                  cr_wait [NumOup];
    logic                stall;
    logic [31:0]         lfsr_q = 32'hb518;

    snoop_interconnect #(
        .NumInp   (NumInp),
        .NumOup   (NumOup),
        .ReqDepth (ReqDepth),
        .SelDepth (SelDepth)
    ) snoop_interconnect_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .inp_ac_valid_i (inp_ac_valid),
        .inp_ac_ready_o (inp_ac_ready),
        .inp_ac_i       (inp_ac),
        .inp_sel_i      (inp_sel),
        .inp_cr_valid_o (inp_cr_valid),
        .inp_cr_ready_i (inp_cr_ready),
        .inp_cr_o       (inp_cr),
        .oup_ac_valid_o (oup_ac_valid),
        .oup_ac_ready_i (oup_ac_ready),
        .oup_ac_o       (oup_ac),
        .oup_cr_valid_i (oup_cr_valid),
        .oup_cr_ready_o (oup_cr_ready),
        .oup_cr_i       (oup_cr)
    );

    snoop_checker #(
        .NumInp (NumInp),
        .NumOup (NumOup)
    ) checker_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .in_ac_valid_i  (inp_ac_valid),
        .in_ac_ready_i  (inp_ac_ready),
        .in_ac_i        (inp_ac),
        .in_sel_i       (inp_sel),
        .in_cr_valid_i  (inp_cr_valid),
        .in_cr_ready_i  (inp_cr_ready),
        .in_cr_i        (inp_cr),
        .out_ac_valid_i (oup_ac_valid),
        .out_ac_ready_i (oup_ac_ready),
        .out_ac_i       (oup_ac),
        .out_cr_ready_i (oup_cr_ready),
        .test_num_i     (test_num),
        .test_end_i     (test_end),
        .run_end_i      (run_end),
        .errors_o       (errors)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // x^32 + x^22 + x^2 + x + 1, one step for every bit handed out.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic snoop_pkg::cr_resp_t target_answer(input snoop_pkg::ac_chan_t ac,
                                                          input int j);
        return snoop_pkg::cr_resp_t'(ac >> snoop_pkg::AcSnoopWidth) ^ snoop_pkg::cr_resp_t'(j);
    endfunction

    task automatic queue_request(input int i, input logic [31:0] addr, input logic [3:0] op,
                                 input logic [NumOup-1:0] sel);
        req_ac[i].push_back({addr, op});
        req_sel[i].push_back(sel);
        issued[i]++;
    endtask

    task automatic wait_for_responses();
        bit all_back;
        all_back = 1'b0;
        while (!all_back) begin
            @(posedge clk_i);
            #1;
            all_back = 1'b1;
            for (int i = 0; i < NumInp; i++) begin
                if (cr_seen[i] != issued[i]) all_back = 1'b0;
            end
        end
    endtask

    task automatic finish_test(input int num);
        @(negedge clk_i);
        test_num = num;
        test_end = 1'b1;
        @(negedge clk_i);
        test_end = 1'b0;
    endtask

    // ==============================
    // handshake sampling
    // ==============================

    always @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < NumInp; i++) begin
                ac_taken[i] = inp_ac_valid[i] && inp_ac_ready[i];
                if (inp_cr_valid[i] && inp_cr_ready[i]) cr_seen[i]++;
            end
            for (int j = 0; j < NumOup; j++) begin
                if (oup_ac_valid[j] && oup_ac_ready[j]) tgt_pend[j].push_back(oup_ac[j]);
                cr_taken[j] = oup_cr_valid[j] && oup_cr_ready[j];
            end
        end
    end

    // ==============================
    // initiator and target models
    // ==============================

    always @(negedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < NumInp; i++) begin
                if (ac_taken[i]) begin
                    req_ac[i].delete(0);
                    req_sel[i].delete(0);
                    ac_taken[i]     = 1'b0;
                    inp_ac_valid[i] = 1'b0;
                end
                if (!inp_ac_valid[i] && req_ac[i].size() != 0 &&
                    (!stall || take_bits(1) != 0)) begin
                    inp_ac_valid[i] = 1'b1;
                    inp_ac[i]       = req_ac[i][0];
                    inp_sel[i]      = req_sel[i][0];
                end
                inp_cr_ready[i] = stall ? (take_bits(2) != 0) : 1'b1;
            end
            for (int j = 0; j < NumOup; j++) begin
                if (cr_taken[j]) begin
                    tgt_pend[j].delete(0);
                    cr_taken[j]     = 1'b0;
                    oup_cr_valid[j] = 1'b0;
                    cr_wait[j]      = stall ? int'(take_bits(2)) : 0;
                end
                if (!oup_cr_valid[j] && tgt_pend[j].size() != 0) begin
                    if (cr_wait[j] == 0) begin
                        oup_cr_valid[j] = 1'b1;
                        oup_cr[j]       = target_answer(tgt_pend[j][0], j);
                    end else begin
                        cr_wait[j]--;
                    end
                end
                oup_ac_ready[j] = stall ? (take_bits(1) != 0) : 1'b1;
            end
        end
    end

    // ==============================
    // tests
    // ==============================

    initial begin
        rst_i        = 1'b1;
        inp_ac_valid = '0;
        inp_ac       = '0;
        inp_sel      = '0;
        inp_cr_ready = '1;
        oup_ac_ready = '1;
        oup_cr_valid = '0;
        oup_cr       = '0;
        ac_taken     = '0;
        cr_taken     = '0;
        stall        = 1'b0;
        test_num     = 0;
        test_end     = 1'b0;
        run_end      = 1'b0;
        for (int i = 0; i < NumInp; i++) begin
            issued[i]  = 0;
            cr_seen[i] = 0;
        end
        for (int j = 0; j < NumOup; j++) cr_wait[j] = 0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        repeat (10) @(posedge clk_i); // idle, nothing may be valid.
        finish_test(1);

        @(posedge clk_i);
        queue_request(0, 32'h8000_1234, 4'h7, 4'b0100);
        wait_for_responses();
        finish_test(2);

        @(posedge clk_i);
        queue_request(1, 32'h0000_abcd, 4'h1, 4'b1111);
        wait_for_responses();
        finish_test(3);

        @(posedge clk_i);
        queue_request(2, 32'h7654_3210, 4'h9, 4'b0000);
        wait_for_responses();
        finish_test(4);

        @(posedge clk_i);
        stall = 1'b1;
        for (int r = 0; r < RandPerInp; r++) begin
            for (int i = 0; i < NumInp; i++) begin
                queue_request(i, take_bits(32), 4'(take_bits(4)), NumOup'(take_bits(NumOup)));
            end
        end
        wait_for_responses();
        stall = 1'b0;
        finish_test(5);

        @(negedge clk_i);
        run_end = 1'b1;
        @(posedge clk_i);
        #1;
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (Watchdog) @(posedge clk_i);
        $display("timeout: the snoops did not complete within %0d cycles", Watchdog);
        $display("Errors found");
        $finish;
    end

endmodule
